// File: hdl/bft_pkg.sv
package bft_pkg;

    // ----------------------------------------------------------------------
    // Network packet geometry
    // ----------------------------------------------------------------------
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    localparam int VALID_BIT    = 48;
    localparam int LEAF_LSB     = 43;  // Leaf field is bits 47..43.
    localparam int PORT_LSB     = 39;  // Port field is bits 42..39.
    localparam int ADDR_LSB     = 32;  // Address field is bits 38..32.
    localparam int PAYLOAD_LSB  = 0;

    // Route entry layout inside a configuration payload.
    localparam int ROUTE_LEAF_LSB = 4;
    localparam int ROUTE_PORT_LSB = 0;

    // ----------------------------------------------------------------------
    // Leaf configuration
    // ----------------------------------------------------------------------
    localparam int NUM_IN_PORTS  = 3;  // Leaf to kernel streams.
    localparam int NUM_OUT_PORTS = 2;  // Kernel to leaf streams.
    localparam int CONFIG_PORT   = 0;
    localparam int FIFO_DEPTH    = 4;

    typedef logic [PACKET_BITS-1:0]  packet_t;
    typedef logic [PAYLOAD_BITS-1:0] payload_t;
    typedef logic [LEAF_BITS-1:0]    leaf_addr_t;
    typedef logic [PORT_BITS-1:0]    port_addr_t;
    typedef logic [ADDR_BITS-1:0]    seq_addr_t;

endpackage

// File: hdl/stream_fifo.sv
`timescale 1ns/100ps
module stream_fifo #(
    parameter int DEPTH = bft_pkg::FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              reset,
    input  bft_pkg::payload_t wr_data,
    input  logic              wr_valid,
    output logic              wr_ready,
    output bft_pkg::payload_t rd_data,
    output logic              rd_valid,
    input  logic              rd_ready
);
    localparam int PTR_BITS = $clog2(DEPTH);

    bft_pkg::payload_t   mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                wr_en;
    logic                rd_en;

    assign wr_ready = count != (PTR_BITS + 1)'(DEPTH);
    assign rd_valid = count != '0;
    assign rd_data  = mem[rd_ptr];  // Show-ahead read.
    assign wr_en    = wr_valid && wr_ready;
    assign rd_en    = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // A write held off by a full buffer stays offered with the same word.
    assert property (@(posedge clk) disable iff (reset)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_data));

endmodule

// File: hdl/leaf_depacketizer.sv
`timescale 1ns/100ps
module leaf_depacketizer (
    input  logic                clk,
    input  logic                reset,
    input  bft_pkg::packet_t    din,
    output logic                din_ready,
    output bft_pkg::payload_t   fifo_data,
    output logic                fifo_valid_1,
    output logic                fifo_valid_2,
    output logic                fifo_valid_3,
    input  logic                fifo_ready_1,
    input  logic                fifo_ready_2,
    input  logic                fifo_ready_3,
    output bft_pkg::leaf_addr_t route_leaf_1,
    output bft_pkg::leaf_addr_t route_leaf_2,
    output bft_pkg::port_addr_t route_port_1,
    output bft_pkg::port_addr_t route_port_2
);
    logic                hold_valid;
    bft_pkg::port_addr_t hold_port;
    bft_pkg::seq_addr_t  hold_addr;
    bft_pkg::payload_t   hold_payload;
    logic                hold_done;
    logic                accept;
    logic                is_config;

    assign accept    = din[bft_pkg::VALID_BIT] && din_ready;
    assign din_ready = !hold_valid || hold_done;
    assign is_config = hold_port == bft_pkg::port_addr_t'(bft_pkg::CONFIG_PORT);

    always_comb begin
        case (hold_port)
            4'd1:    hold_done = fifo_ready_1;
            4'd2:    hold_done = fifo_ready_2;
            4'd3:    hold_done = fifo_ready_3;
            default: hold_done = 1'b1;  // Config retires in one cycle.
        endcase
    end

    assign fifo_data    = hold_payload;
    assign fifo_valid_1 = hold_valid && hold_port == 4'd1;
    assign fifo_valid_2 = hold_valid && hold_port == 4'd2;
    assign fifo_valid_3 = hold_valid && hold_port == 4'd3;

    // ----------------------------------------------------------------------
    // Packet holding register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (hold_done) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_port    <= din[bft_pkg::PORT_LSB +: bft_pkg::PORT_BITS];
            hold_addr    <= din[bft_pkg::ADDR_LSB +: bft_pkg::ADDR_BITS];
            hold_payload <= din[bft_pkg::PAYLOAD_LSB +: bft_pkg::PAYLOAD_BITS];
        end
    end

    // ----------------------------------------------------------------------
    // Route table, one entry per output port
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            route_leaf_1 <= '0;
            route_leaf_2 <= '0;
            route_port_1 <= '0;
            route_port_2 <= '0;
        end else if (hold_valid && is_config) begin
            if (hold_addr == 7'd1) begin
                route_leaf_1 <= hold_payload[bft_pkg::ROUTE_LEAF_LSB +: bft_pkg::LEAF_BITS];
                route_port_1 <= hold_payload[bft_pkg::ROUTE_PORT_LSB +: bft_pkg::PORT_BITS];
            end
            if (hold_addr == 7'd2) begin
                route_leaf_2 <= hold_payload[bft_pkg::ROUTE_LEAF_LSB +: bft_pkg::LEAF_BITS];
                route_port_2 <= hold_payload[bft_pkg::ROUTE_PORT_LSB +: bft_pkg::PORT_BITS];
            end
        end
    end

    // Network must only address the config port and the three streams.
    assert property (@(posedge clk) disable iff (reset)
        accept |=> hold_port <= bft_pkg::port_addr_t'(bft_pkg::NUM_IN_PORTS));

endmodule

// File: hdl/leaf_packetizer.sv
`timescale 1ns/100ps
module leaf_packetizer (
    input  logic                clk,
    input  logic                reset,
    input  logic                resend,
    input  bft_pkg::payload_t   out_data_1,
    input  bft_pkg::payload_t   out_data_2,
    input  logic                out_valid_1,
    input  logic                out_valid_2,
    output logic                out_ready_1,
    output logic                out_ready_2,
    input  bft_pkg::leaf_addr_t route_leaf_1,
    input  bft_pkg::leaf_addr_t route_leaf_2,
    input  bft_pkg::port_addr_t route_port_1,
    input  bft_pkg::port_addr_t route_port_2,
    output bft_pkg::packet_t    dout
);
    typedef enum logic {
        LAST_1,
        LAST_2
    } grant_e;

    grant_e             last_grant;
    bft_pkg::seq_addr_t seq [bft_pkg::NUM_OUT_PORTS];
    bft_pkg::packet_t   pkt;
    logic               grant_1;
    logic               grant_2;

    // ----------------------------------------------------------------------
    // Round-robin arbitration
    // ----------------------------------------------------------------------
    assign grant_1 = !resend && out_valid_1 && (!out_valid_2 || last_grant == LAST_2);
    assign grant_2 = !resend && out_valid_2 && (!out_valid_1 || last_grant == LAST_1);

    assign out_ready_1 = grant_1;
    assign out_ready_2 = grant_2;

    // ----------------------------------------------------------------------
    // Packet assembly
    // ----------------------------------------------------------------------
    always_comb begin
        pkt = '0;
        if (grant_1 || grant_2) begin
            pkt[bft_pkg::VALID_BIT] = 1'b1;
            pkt[bft_pkg::LEAF_LSB +: bft_pkg::LEAF_BITS] = grant_2 ? route_leaf_2 : route_leaf_1;
            pkt[bft_pkg::PORT_LSB +: bft_pkg::PORT_BITS] = grant_2 ? route_port_2 : route_port_1;
            pkt[bft_pkg::ADDR_LSB +: bft_pkg::ADDR_BITS] = seq[grant_2];
            pkt[bft_pkg::PAYLOAD_LSB +: bft_pkg::PAYLOAD_BITS] =
                grant_2 ? out_data_2 : out_data_1;
        end
    end

    // Packet in dout was delivered unless resend was high this cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            dout       <= '0;
            last_grant <= LAST_2;  // Port 1 wins the first tie.
            for (int i = 0; i < bft_pkg::NUM_OUT_PORTS; i++) begin
                seq[i] <= '0;
            end
        end else if (!resend) begin
            dout <= pkt;
            if (grant_1) begin
                last_grant <= LAST_1;
                seq[0]     <= seq[0] + 1'b1;  // Wraps at 128.
            end
            if (grant_2) begin
                last_grant <= LAST_2;
                seq[1]     <= seq[1] + 1'b1;
            end
        end
    end

    // A kernel word that is not taken stays offered unchanged.
    assert property (@(posedge clk) disable iff (reset)
        out_valid_1 && !out_ready_1 |=> out_valid_1 && $stable(out_data_1));
    assert property (@(posedge clk) disable iff (reset)
        out_valid_2 && !out_ready_2 |=> out_valid_2 && $stable(out_data_2));

endmodule

// File: hdl/leaf_interface.sv
`timescale 1ns/100ps
module leaf_interface (
    input  logic              clk,
    input  logic              reset,
    input  logic              resend,
    input  bft_pkg::packet_t  din,
    output logic              din_ready,
    output bft_pkg::packet_t  dout,
    output bft_pkg::payload_t in_data_1,
    output bft_pkg::payload_t in_data_2,
    output bft_pkg::payload_t in_data_3,
    output logic              in_valid_1,
    output logic              in_valid_2,
    output logic              in_valid_3,
    input  logic              in_ready_1,
    input  logic              in_ready_2,
    input  logic              in_ready_3,
    input  bft_pkg::payload_t out_data_1,
    input  bft_pkg::payload_t out_data_2,
    input  logic              out_valid_1,
    input  logic              out_valid_2,
    output logic              out_ready_1,
    output logic              out_ready_2
);
    bft_pkg::payload_t                   fifo_data;
    logic [bft_pkg::NUM_IN_PORTS-1:0]    wr_valid;
    logic [bft_pkg::NUM_IN_PORTS-1:0]    wr_ready;
    logic [bft_pkg::NUM_IN_PORTS-1:0]    rd_valid;
    logic [bft_pkg::NUM_IN_PORTS-1:0]    rd_ready;
    bft_pkg::payload_t                   rd_data [bft_pkg::NUM_IN_PORTS];
    bft_pkg::leaf_addr_t                 route_leaf_1;
    bft_pkg::leaf_addr_t                 route_leaf_2;
    bft_pkg::port_addr_t                 route_port_1;
    bft_pkg::port_addr_t                 route_port_2;

    leaf_depacketizer u_depacketizer (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .din_ready    (din_ready),
        .fifo_data    (fifo_data),
        .fifo_valid_1 (wr_valid[0]),
        .fifo_valid_2 (wr_valid[1]),
        .fifo_valid_3 (wr_valid[2]),
        .fifo_ready_1 (wr_ready[0]),
        .fifo_ready_2 (wr_ready[1]),
        .fifo_ready_3 (wr_ready[2]),
        .route_leaf_1 (route_leaf_1),
        .route_leaf_2 (route_leaf_2),
        .route_port_1 (route_port_1),
        .route_port_2 (route_port_2)
    );

    for (genvar i = 0; i < bft_pkg::NUM_IN_PORTS; i++) begin : g_in_fifo
        stream_fifo #(
            .DEPTH (bft_pkg::FIFO_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .reset    (reset),
            .wr_data  (fifo_data),
            .wr_valid (wr_valid[i]),
            .wr_ready (wr_ready[i]),
            .rd_data  (rd_data[i]),
            .rd_valid (rd_valid[i]),
            .rd_ready (rd_ready[i])
        );
    end

    assign in_data_1  = rd_data[0];
    assign in_data_2  = rd_data[1];
    assign in_data_3  = rd_data[2];
    assign in_valid_1 = rd_valid[0];
    assign in_valid_2 = rd_valid[1];
    assign in_valid_3 = rd_valid[2];
    assign rd_ready   = {in_ready_3, in_ready_2, in_ready_1};

    leaf_packetizer u_packetizer (
        .clk          (clk),
        .reset        (reset),
        .resend       (resend),
        .out_data_1   (out_data_1),
        .out_data_2   (out_data_2),
        .out_valid_1  (out_valid_1),
        .out_valid_2  (out_valid_2),
        .out_ready_1  (out_ready_1),
        .out_ready_2  (out_ready_2),
        .route_leaf_1 (route_leaf_1),
        .route_leaf_2 (route_leaf_2),
        .route_port_1 (route_port_1),
        .route_port_2 (route_port_2),
        .dout         (dout)
    );

endmodule

// File: hdl/user_kernel.sv
`timescale 1ns/100ps
module user_kernel (
    input  logic              clk,
    input  logic              reset,
    input  bft_pkg::payload_t in_data_1,
    input  bft_pkg::payload_t in_data_2,
    input  bft_pkg::payload_t in_data_3,
    input  logic              in_valid_1,
    input  logic              in_valid_2,
    input  logic              in_valid_3,
    output logic              in_ready_1,
    output logic              in_ready_2,
    output logic              in_ready_3,
    output bft_pkg::payload_t out_data_1,
    output bft_pkg::payload_t out_data_2,
    output logic              out_valid_1,
    output logic              out_valid_2,
    input  logic              out_ready_1,
    input  logic              out_ready_2
);
    logic take_sum;
    logic take_rev;

    // Adder consumes streams 1 and 2 only as a pair.
    assign take_sum   = in_valid_1 && in_valid_2 && (!out_valid_1 || out_ready_1);
    assign in_ready_1 = take_sum;
    assign in_ready_2 = take_sum;

    assign in_ready_3 = !out_valid_2 || out_ready_2;
    assign take_rev   = in_valid_3 && in_ready_3;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_1 <= 1'b0;
            out_valid_2 <= 1'b0;
        end else begin
            if (take_sum) begin
                out_valid_1 <= 1'b1;
            end else if (out_ready_1) begin
                out_valid_1 <= 1'b0;
            end
            if (take_rev) begin
                out_valid_2 <= 1'b1;
            end else if (out_ready_2) begin
                out_valid_2 <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_sum) begin
            out_data_1 <= in_data_1 + in_data_2;  // Modulo 2**32.
        end
        if (take_rev) begin
            out_data_2 <= {in_data_3[7:0], in_data_3[15:8], in_data_3[23:16], in_data_3[31:24]};
        end
    end

endmodule

// File: hdl/leaf_top.sv
`timescale 1ns/100ps
module leaf_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             resend,
    input  bft_pkg::packet_t din,
    output logic             din_ready,
    output bft_pkg::packet_t dout
);
    bft_pkg::payload_t in_data_1, in_data_2, in_data_3;
    logic              in_valid_1, in_valid_2, in_valid_3;
    logic              in_ready_1, in_ready_2, in_ready_3;
    bft_pkg::payload_t out_data_1, out_data_2;
    logic              out_valid_1, out_valid_2;
    logic              out_ready_1, out_ready_2;
    bft_pkg::packet_t  dout_raw;

    // Network sees nothing while it asks for a resend.
    assign dout = resend ? '0 : dout_raw;

    leaf_interface u_leaf_interface (
        .dout (dout_raw),
        .*
    );

    user_kernel u_user_kernel (
        .*
    );

endmodule

// File: verification/leaf_tb.sv
`timescale 1ns/100ps
module leaf_tb;

    localparam string TEST_FILE = "verification/leaf_tests.txt";

    logic                clk        = 1'b0;
    logic                reset      = 1'b1;
    logic                resend     = 1'b0;
    bft_pkg::packet_t    din        = '0;
    logic                din_ready;
    bft_pkg::packet_t    dout;

    bft_pkg::packet_t    stim_q [$];
    bft_pkg::packet_t    exp_q_1 [$];
    bft_pkg::packet_t    exp_q_2 [$];
    int                  win_start [$];
    int                  win_len [$];
    bft_pkg::leaf_addr_t cfg_leaf_1 = '0;
    bft_pkg::leaf_addr_t cfg_leaf_2 = '0;
    bft_pkg::port_addr_t cfg_port_1 = '0;
    bft_pkg::port_addr_t cfg_port_2 = '0;
    int                  test_lines = 0;
    int                  resend_end = 0;
    int                  cycle      = 0;
    logic                loaded     = 1'b0;

    leaf_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .resend    (resend),
        .din       (din),
        .din_ready (din_ready),
        .dout      (dout)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    function automatic bft_pkg::packet_t make_packet(input int leaf, input int port,
                                                     input int addr, input bft_pkg::payload_t w);
        bft_pkg::packet_t p;
        p = '0;
        p[bft_pkg::VALID_BIT] = 1'b1;
        p[bft_pkg::LEAF_LSB +: bft_pkg::LEAF_BITS] = bft_pkg::leaf_addr_t'(leaf);
        p[bft_pkg::PORT_LSB +: bft_pkg::PORT_BITS] = bft_pkg::port_addr_t'(port);
        p[bft_pkg::ADDR_LSB +: bft_pkg::ADDR_BITS] = bft_pkg::seq_addr_t'(addr);
        p[bft_pkg::PAYLOAD_LSB +: bft_pkg::PAYLOAD_BITS] = w;
        return p;
    endfunction

    // ------------------------------------------------------------------
    // Test file parsing
    // ------------------------------------------------------------------
    task automatic load_tests();
        int                fd;
        int                n;
        int                a;
        int                b;
        int                c;
        int                d;
        bft_pkg::payload_t w;
        string             kind;
        string             rest;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) abort_run("Could not open the test file.");
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                n = $fgets(rest, fd);  // Skip the rest of a comment line.
            end else if (kind == "C") begin
                n = $fscanf(fd, "%d %h %h", a, b, c);
                if (n != 3 || a < 1 || a > 2) abort_run("Malformed configuration line.");
                w = (bft_pkg::payload_t'(b) << bft_pkg::ROUTE_LEAF_LSB) | bft_pkg::payload_t'(c);
                if (a == 1) begin
                    cfg_leaf_1 = bft_pkg::leaf_addr_t'(b);
                    cfg_port_1 = bft_pkg::port_addr_t'(c);
                end else begin
                    cfg_leaf_2 = bft_pkg::leaf_addr_t'(b);
                    cfg_port_2 = bft_pkg::port_addr_t'(c);
                end
                stim_q.push_back(make_packet(0, bft_pkg::CONFIG_PORT, a, w));
            end else if (kind == "D") begin
                n = $fscanf(fd, "%d %h", a, w);
                if (n != 2 || a < 1 || a > 3) abort_run("Malformed data line.");
                stim_q.push_back(make_packet(0, a, 0, w));
            end else if (kind == "R") begin
                n = $fscanf(fd, "%d %d", a, b);
                if (n != 2) abort_run("Malformed resend line.");
                win_start.push_back(a);
                win_len.push_back(b);
                if (a + b > resend_end) resend_end = a + b;
            end else if (kind == "E") begin
                n = $fscanf(fd, "%d %h %h %h %h", a, b, c, d, w);
                if (n != 5 || a < 1 || a > 2) abort_run("Malformed expected line.");
                if (a == 1) exp_q_1.push_back(make_packet(b, c, d, w));
                else exp_q_2.push_back(make_packet(b, c, d, w));
            end else begin
                abort_run("Unknown line kind in the test file.");
            end
            if (kind != "#") test_lines++;
        end
        $fclose(fd);
    endtask

    function automatic logic in_resend_window(input int c);
        foreach (win_start[i]) begin
            if (c >= win_start[i] && c < win_start[i] + win_len[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic int route_index(input bft_pkg::packet_t p);
        bft_pkg::leaf_addr_t leaf;
        bft_pkg::port_addr_t port;
        leaf = p[bft_pkg::LEAF_LSB +: bft_pkg::LEAF_BITS];
        port = p[bft_pkg::PORT_LSB +: bft_pkg::PORT_BITS];
        if (leaf == cfg_leaf_1 && port == cfg_port_1) return 1;
        if (leaf == cfg_leaf_2 && port == cfg_port_2) return 2;
        return 0;
    endfunction

    task automatic check_packet(input bft_pkg::packet_t expected);
        assert (dout == expected) else begin
            $display("ERR dout expected %h actual %h", expected, dout);
            abort_run("Packet on dout does not match.");
        end
    endtask

    // ------------------------------------------------------------------
    // Resend windows and output monitor
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (reset) cycle = 0;
        else cycle = cycle + 1;
        #0.5;
        resend = in_resend_window(cycle);
    end

    always @(negedge clk) begin
        int out_port;
        if (!reset) begin
            if (resend) begin
                check_packet('0);  // Output is blanked during resend.
            end else if (dout[bft_pkg::VALID_BIT]) begin
                out_port = route_index(dout);
                if (out_port == 1) begin
                    assert (exp_q_1.size() != 0)
                        else abort_run("Output port 1 sent more packets than expected.");
                    check_packet(exp_q_1.pop_front());
                end else if (out_port == 2) begin
                    assert (exp_q_2.size() != 0)
                        else abort_run("Output port 2 sent more packets than expected.");
                    check_packet(exp_q_2.pop_front());
                end else begin
                    abort_run("Packet on dout has a destination that no route entry holds.");
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (40 * test_lines + 200) @(posedge clk);
        abort_run("Timeout: the expected packets did not all arrive in time.");
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        int   gap;
        logic accepted;
        logic saw_din_stall;
        saw_din_stall = 1'b0;
        void'($urandom(32'h56d3_5c9d));
        load_tests();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #0.5;
        reset = 1'b0;
        assert (din_ready == 1'b1) else begin
            $display("ERR din_ready expected %h actual %h", 1'b1, din_ready);
            abort_run("din_ready is low right after reset.");
        end
        while (stim_q.size() != 0) begin
            din      = stim_q.pop_front();
            accepted = 1'b0;
            while (!accepted) begin
                accepted = din_ready;  // Taken at the coming edge.
                if (!din_ready) saw_din_stall = 1'b1;
                @(posedge clk);
                #0.5;
            end
            din = '0;
            gap = $urandom_range(3, 0);
            repeat (gap) begin
                @(posedge clk);
                #0.5;
            end
        end
        while (exp_q_1.size() != 0 || exp_q_2.size() != 0 || cycle < resend_end) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);  // Room for stray extra packets.
        if (saw_din_stall) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("din_ready never dropped while a packet was offered.");
        end
    end

endmodule

// File: leaf_top.f
hdl/bft_pkg.sv
hdl/stream_fifo.sv
hdl/leaf_depacketizer.sv
hdl/leaf_packetizer.sv
hdl/leaf_interface.sv
hdl/user_kernel.sv
hdl/leaf_top.sv
verification/leaf_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the leaf testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module leaf_tb -f leaf_top.f

status=0
./obj_dir/Vleaf_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Regression passed" sim.log; then
    echo "Simulation PASS"
    exit 0
else
    echo "Simulation FAIL"
    exit 1
fi

// File: verification/leaf_tests.txt
# C out_port leaf port | D port payload | R start_cycle length
# E out_port leaf port seq payload (leaf, port, seq and payload in hex)
C 1 05 3
C 2 12 7
R 6 3
R 14 2
R 24 60
D 1 00000001
D 2 00000002
D 1 ffffffff
D 2 00000005
D 3 11223344
D 1 80000000
D 2 80000000
D 3 deadbeef
D 1 12345678
D 2 87654321
D 3 a1b2c3d4
# Port 1 words wait here for partners that come after the port 3 burst
D 1 00000010
D 1 00000020
D 1 00000030
D 3 01020304
D 3 0a0b0c0d
D 3 00ff00ff
D 3 12000034
D 3 cafef00d
D 3 0000abcd
D 2 00000001
D 2 00000002
D 2 00000003
E 1 05 3 0 00000003
E 1 05 3 1 00000004
E 1 05 3 2 00000000
E 1 05 3 3 99999999
E 1 05 3 4 00000011
E 1 05 3 5 00000022
E 1 05 3 6 00000033
E 2 12 7 0 44332211
E 2 12 7 1 efbeadde
E 2 12 7 2 d4c3b2a1
E 2 12 7 3 04030201
E 2 12 7 4 0d0c0b0a
E 2 12 7 5 ff00ff00
E 2 12 7 6 34000012
E 2 12 7 7 0df0feca
E 2 12 7 8 cdab0000
